/* common/md5Pkg.sv */
`default_nettype none

package md5Pkg;

	// Widths with a meaning in MD5
	typedef logic [31:0] md5Word;
	typedef logic [3:0] byteLen;
	typedef logic [5:0] stepIdx;
	typedef logic [7:0] apbAddr;

	// Step sequencing states
	typedef enum logic [1:0] {
		Idle,
		Run,
		Finish
	} ctrlState;

	// Standard chaining values
	localparam md5Word initA = 32'h67452301;
	localparam md5Word initB = 32'hefcdab89;
	localparam md5Word initC = 32'h98badcfe;
	localparam md5Word initD = 32'h10325476;

	// Additive constants T, one per step
	localparam md5Word sineTable [64] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	// Rotate amounts, row per round, column is step mod 4
	localparam logic [4:0] shiftTable [16] = '{
		5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9, 5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21
	};

	// APB register map
	localparam apbAddr guessAddr0 = 8'h00;
	localparam apbAddr lenAddr = 8'h10;
	localparam apbAddr ctrlAddr = 8'h14;
	localparam apbAddr digestAddr0 = 8'h20;

	// Message word used by a step, wraps mod 16
	function automatic logic [3:0] msgIndex(stepIdx s);
		logic [3:0] i;
		i = s[3:0];
		case (s[5:4])
			2'd0: return i;
			2'd1: return 4'(5 * i + 1);
			2'd2: return 4'(3 * i + 5);
			default: return 4'(7 * i);
		endcase
	endfunction

	// F, G, H, I by round number
	function automatic md5Word roundFunc(logic [1:0] round, md5Word b, md5Word c, md5Word d);
		case (round)
			2'd0: return (b & c) | (~b & d);
			2'd1: return (b & d) | (c & ~d);
			2'd2: return b ^ c ^ d;
			default: return c ^ (b | ~d);
		endcase
	endfunction

	// Left rotate via doubled word
	function automatic md5Word rotateLeft(md5Word x, logic [4:0] amount);
		logic [63:0] doubled;
		doubled = {x, x} << amount;
		return doubled[63:32];
	endfunction

endpackage

`default_nettype wire

/* common/md5StateIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Four MD5 chaining words
interface md5StateIf;

	md5Pkg::md5Word a;
	md5Pkg::md5Word b;
	md5Pkg::md5Word c;
	md5Pkg::md5Word d;

	// Producer drives all four words
	modport source (
		output a, b, c, d
	);

	// Consumer only reads them
	modport sink (
		input a, b, c, d
	);

endinterface

`default_nettype wire

/* md5Core/md5DigestAdd.sv */
`timescale 1ns/1ps
`default_nettype none

module md5DigestAdd (
	input logic clk,
	input logic rst,
	input logic capture,
	md5StateIf.sink state,
	md5StateIf.source digest
);

	md5Pkg::md5Word digA;
	md5Pkg::md5Word digB;
	md5Pkg::md5Word digC;
	md5Pkg::md5Word digD;

	// Final feed-forward of the initial values
	always_ff @(posedge clk) begin
		if (rst) begin
			digA <= '0;
			digB <= '0;
			digC <= '0;
			digD <= '0;
		end else if (capture) begin
			digA <= state.a + md5Pkg::initA;
			digB <= state.b + md5Pkg::initB;
			digC <= state.c + md5Pkg::initC;
			digD <= state.d + md5Pkg::initD;
		end
	end

	// Held until next capture
	assign digest.a = digA;
	assign digest.b = digB;
	assign digest.c = digC;
	assign digest.d = digD;

endmodule

`default_nettype wire

/* md5Core/md5MessagePad.sv */
`timescale 1ns/1ps
`default_nettype none

module md5MessagePad (
	input logic clk,
	input logic load,
	input md5Pkg::md5Word guess0,
	input md5Pkg::md5Word guess1,
	input md5Pkg::md5Word guess2,
	input md5Pkg::md5Word guess3,
	input md5Pkg::byteLen guessLen,
	input md5Pkg::stepIdx step,
	output md5Pkg::md5Word msgWord
);

	md5Pkg::md5Word guessWords [4];
	md5Pkg::md5Word padded [16];
	md5Pkg::md5Word block [16];

	assign guessWords[0] = guess0;
	assign guessWords[1] = guess1;
	assign guessWords[2] = guess2;
	assign guessWords[3] = guess3;

	// Padded block from guess and length
	always_comb begin
		for (int w = 0; w < 16; w++)
			padded[w] = '0;
		for (int i = 0; i < 16; i++) begin
			// Byte i lives in word i/4, lane i mod 4
			if (i < int'(guessLen))
				padded[i / 4][8 * (i % 4) +: 8] = guessWords[i / 4][8 * (i % 4) +: 8];
			else if (i == int'(guessLen))
				padded[i / 4][8 * (i % 4) +: 8] = 8'h80;
		end
		// Bit length, low word only
		padded[14] = {25'b0, guessLen, 3'b000};
	end

	// Held for the whole run
	always_ff @(posedge clk) begin
		if (load)
			block <= padded;
	end

	// Word order changes per round
	assign msgWord = block[md5Pkg::msgIndex(step)];

endmodule

`default_nettype wire

/* md5Core/md5RoundStep.sv */
`timescale 1ns/1ps
`default_nettype none

module md5RoundStep (
	input logic clk,
	input logic load,
	input logic advance,
	input md5Pkg::stepIdx step,
	input md5Pkg::md5Word msgWord,
	md5StateIf.source state
);

	md5Pkg::md5Word aReg;
	md5Pkg::md5Word bReg;
	md5Pkg::md5Word cReg;
	md5Pkg::md5Word dReg;
	logic [1:0] round;
	md5Pkg::md5Word funcVal;
	md5Pkg::md5Word stepSum;
	md5Pkg::md5Word newB;

	// Round number picks F, G, H or I
	assign round = step[5:4];
	assign funcVal = md5Pkg::roundFunc(round, bReg, cReg, dReg);

	// Add chain, then rotate and add B
	assign stepSum = aReg + funcVal + msgWord + md5Pkg::sineTable[step];
	assign newB = bReg + md5Pkg::rotateLeft(stepSum, md5Pkg::shiftTable[{round, step[1:0]}]);

	always_ff @(posedge clk) begin
		if (load) begin
			aReg <= md5Pkg::initA;
			bReg <= md5Pkg::initB;
			cReg <= md5Pkg::initC;
			dReg <= md5Pkg::initD;
		end else if (advance) begin
			// Word rotation after each step
			aReg <= dReg;
			bReg <= newB;
			cReg <= bReg;
			dReg <= cReg;
		end
	end

	assign state.a = aReg;
	assign state.b = bReg;
	assign state.c = cReg;
	assign state.d = dReg;

endmodule

`default_nettype wire

/* md5Hasher.f */
common/md5Pkg.sv
common/md5StateIf.sv
rtl/md5ApbRegs.sv
rtl/md5Control.sv
md5Core/md5MessagePad.sv
md5Core/md5RoundStep.sv
md5Core/md5DigestAdd.sv
rtl/md5Hasher.sv
+incdir+testbench
testbench/md5HasherTb.sv

/* rtl/md5ApbRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module md5ApbRegs (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input md5Pkg::apbAddr paddr,
	input md5Pkg::md5Word pwdata,
	output md5Pkg::md5Word prdata,
	output logic pready,
	output logic pslverr,
	output md5Pkg::md5Word guess0,
	output md5Pkg::md5Word guess1,
	output md5Pkg::md5Word guess2,
	output md5Pkg::md5Word guess3,
	output md5Pkg::byteLen guessLen,
	output logic startReq,
	input logic busy,
	input logic done,
	md5StateIf.sink digest
);

	md5Pkg::md5Word guessReg [4];
	md5Pkg::byteLen lenReg;
	logic accessPhase;
	logic wrEn;
	logic rdEn;
	logic aligned;
	logic guessHit;
	logic lenHit;
	logic ctrlHit;
	logic digestHit;
	logic mapped;
	md5Pkg::md5Word rdMux;

	// Access phase of a transfer
	assign accessPhase = psel && penable;
	assign wrEn = accessPhase && pwrite;
	assign rdEn = accessPhase && !pwrite;

	// Address decode, word aligned only
	assign aligned = paddr[1:0] == 2'b00;
	assign guessHit = aligned && (paddr[7:4] == md5Pkg::guessAddr0[7:4]);
	assign digestHit = aligned && (paddr[7:4] == md5Pkg::digestAddr0[7:4]);
	assign lenHit = paddr == md5Pkg::lenAddr;
	assign ctrlHit = paddr == md5Pkg::ctrlAddr;
	assign mapped = guessHit || digestHit || lenHit || ctrlHit;

	// No wait states
	assign pready = 1'b1;
	assign pslverr = accessPhase && !mapped;

	// Start pulse, same cycle as the write completes
	assign startReq = wrEn && ctrlHit && pwdata[0];

	// Guess and length storage
	always_ff @(posedge clk) begin
		if (rst) begin
			guessReg <= '{default: '0};
			lenReg <= '0;
		end else if (wrEn) begin
			if (guessHit)
				guessReg[paddr[3:2]] <= pwdata;
			// Upper length bits are dropped
			if (lenHit)
				lenReg <= pwdata[3:0];
		end
	end

	assign guess0 = guessReg[0];
	assign guess1 = guessReg[1];
	assign guess2 = guessReg[2];
	assign guess3 = guessReg[3];
	assign guessLen = lenReg;

	// Read mux
	always_comb begin
		rdMux = '0;
		if (guessHit)
			rdMux = guessReg[paddr[3:2]];
		else if (lenHit)
			rdMux = {28'b0, lenReg};
		else if (ctrlHit)
			rdMux = {30'b0, done, busy};
		else if (digestHit) begin
			case (paddr[3:2])
				2'd0: rdMux = digest.a;
				2'd1: rdMux = digest.b;
				2'd2: rdMux = digest.c;
				default: rdMux = digest.d;
			endcase
		end
	end

	// Data only valid in a read access phase
	assign prdata = rdEn ? rdMux : '0;

endmodule

`default_nettype wire

/* rtl/md5Control.sv */
`timescale 1ns/1ps
`default_nettype none

module md5Control (
	input logic clk,
	input logic rst,
	input logic startReq,
	output logic load,
	output logic advance,
	output logic capture,
	output logic busy,
	output logic done,
	output md5Pkg::stepIdx step
);

	md5Pkg::ctrlState state;
	logic doneReg;
	md5Pkg::stepIdx stepCnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= md5Pkg::Idle;
			stepCnt <= '0;
			doneReg <= 1'b0;
		end else begin
			case (state)
				md5Pkg::Idle: begin
					// Accepted start clears the old result flag
					if (startReq) begin
						state <= md5Pkg::Run;
						stepCnt <= '0;
						doneReg <= 1'b0;
					end
				end
				md5Pkg::Run: begin
					stepCnt <= stepCnt + 6'd1;
					// Last of the 64 steps
					if (stepCnt == 6'd63)
						state <= md5Pkg::Finish;
				end
				md5Pkg::Finish: begin
					state <= md5Pkg::Idle;
					doneReg <= 1'b1;
				end
				default: state <= md5Pkg::Idle;
			endcase
		end
	end

	// Starts while busy are simply not seen
	assign load = (state == md5Pkg::Idle) && startReq;
	assign advance = state == md5Pkg::Run;
	assign capture = state == md5Pkg::Finish;
	assign busy = state != md5Pkg::Idle;
	assign done = doneReg;
	assign step = stepCnt;

endmodule

`default_nettype wire

/* rtl/md5Hasher.sv */
`timescale 1ns/1ps
`default_nettype none

module md5Hasher (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input md5Pkg::apbAddr paddr,
	input md5Pkg::md5Word pwdata,
	output md5Pkg::md5Word prdata,
	output logic pready,
	output logic pslverr
);

	md5Pkg::md5Word guess0;
	md5Pkg::md5Word guess1;
	md5Pkg::md5Word guess2;
	md5Pkg::md5Word guess3;
	md5Pkg::byteLen guessLen;
	logic startReq;
	logic busy;
	logic done;
	logic load;
	logic advance;
	logic capture;
	md5Pkg::stepIdx step;
	md5Pkg::md5Word msgWord;

	// Working state and held digest
	md5StateIf workState ();
	md5StateIf digestState ();

	md5ApbRegs apbRegs (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.guess0(guess0),
		.guess1(guess1),
		.guess2(guess2),
		.guess3(guess3),
		.guessLen(guessLen),
		.startReq(startReq),
		.busy(busy),
		.done(done),
		.digest(digestState.sink)
	);

	md5Control control (
		.clk(clk),
		.rst(rst),
		.startReq(startReq),
		.load(load),
		.advance(advance),
		.capture(capture),
		.busy(busy),
		.done(done),
		.step(step)
	);

	md5MessagePad messagePad (
		.clk(clk),
		.load(load),
		.guess0(guess0),
		.guess1(guess1),
		.guess2(guess2),
		.guess3(guess3),
		.guessLen(guessLen),
		.step(step),
		.msgWord(msgWord)
	);

	md5RoundStep roundStep (
		.clk(clk),
		.load(load),
		.advance(advance),
		.step(step),
		.msgWord(msgWord),
		.state(workState.source)
	);

	md5DigestAdd digestAdd (
		.clk(clk),
		.rst(rst),
		.capture(capture),
		.state(workState.sink),
		.digest(digestState.source)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the md5Hasher testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module md5HasherTb \
	-f md5Hasher.f
# A $fatal in the testbench gives a nonzero exit status
./obj_dir/Vmd5HasherTb

/* testbench/md5RefModel.svh */
`ifndef md5RefModelSvh
`define md5RefModelSvh

// Additive constants, one per step
localparam logic [31:0] refSine [64] = '{
	32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
	32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
	32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
	32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
	32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
	32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
	32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
	32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
	32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
	32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
	32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
	32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
	32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
	32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
	32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
	32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
};

// Rotate amounts, four per round
localparam int refShift [16] = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};

// Chaining start values A to D
localparam logic [31:0] refInit [4] = '{32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};

// MD5 of a message under 16 bytes, result is {A, B, C, D}
function automatic logic [127:0] md5Reference(input logic [7:0] msg [16], input int len);
	logic [7:0] blk [64];
	logic [31:0] m [16];
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	logic [31:0] d;
	logic [31:0] f;
	logic [31:0] sum;
	logic [31:0] tmp;
	int g;
	int s;
	// Bytes past the length are never looked at
	for (int i = 0; i < 64; i++)
		blk[i] = 8'h00;
	for (int i = 0; i < len; i++)
		blk[i] = msg[i];
	blk[len] = 8'h80;
	// Bit count, fits in one byte here
	blk[56] = 8'(len * 8);
	for (int w = 0; w < 16; w++)
		m[w] = {blk[4 * w + 3], blk[4 * w + 2], blk[4 * w + 1], blk[4 * w]};
	a = refInit[0];
	b = refInit[1];
	c = refInit[2];
	d = refInit[3];
	for (int i = 0; i < 64; i++) begin
		if (i < 16) begin
			f = (b & c) | (~b & d);
			g = i;
		end else if (i < 32) begin
			f = (d & b) | (~d & c);
			g = (5 * i + 1) % 16;
		end else if (i < 48) begin
			f = b ^ c ^ d;
			g = (3 * i + 5) % 16;
		end else begin
			f = c ^ (b | ~d);
			g = (7 * i) % 16;
		end
		sum = a + f + refSine[i] + m[g];
		s = refShift[(i / 16) * 4 + i % 4];
		tmp = d;
		d = c;
		c = b;
		b = b + ((sum << s) | (sum >> (32 - s)));
		a = tmp;
	end
	return {a + refInit[0], b + refInit[1], c + refInit[2], d + refInit[3]};
endfunction

`endif

/* testbench/md5HasherTb.sv */
`timescale 1ns/1ps
`default_nettype none

module md5HasherTb;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 4;
	localparam int randomRuns = 100;
	// Start write to done read, with the 3-cycle poll cadence
	localparam int doneLimit = 66;
	// About 105 hashes at roughly 100 cycles each, plus margin
	localparam int timeoutCycles = 20000;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	// Cycle stamp of the last access phase, and of the last start
	int cycleCount;
	int accessCycle;
	int startCycle;
	logic lastErr;

	`include "md5RefModel.svh"

	md5Hasher DUT (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Run limit
	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
		$display("CHECKS FAILED");
		$fatal(1, "simulation timeout");
	end

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Setup, access, sample mid-access, complete
	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		lastErr = pslverr;
		accessCycle = cycleCount;
		// No wait states on this slave
		checkValue("pready in write access", {31'b0, pready}, 32'h1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	// prdata is combinational, so read it at the falling edge
	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		lastErr = pslverr;
		accessCycle = cycleCount;
		checkValue("pready in read access", {31'b0, pready}, 32'h1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	function automatic logic [31:0] swapBytes(input logic [31:0] x);
		return {x[7:0], x[15:8], x[23:16], x[31:24]};
	endfunction

	// Printed digest hex to the A to D words
	function automatic logic [127:0] fromHexDigest(input logic [127:0] hex);
		logic [127:0] words;
		for (int k = 0; k < 4; k++)
			words[127 - 32 * k -: 32] = swapBytes(hex[127 - 32 * k -: 32]);
		return words;
	endfunction

	task automatic compareDigest(input string what, input logic [127:0] got,
			input logic [127:0] exp);
		checkValue({what, " word A"}, got[127:96], exp[127:96]);
		checkValue({what, " word B"}, got[95:64], exp[95:64]);
		checkValue({what, " word C"}, got[63:32], exp[63:32]);
		checkValue({what, " word D"}, got[31:0], exp[31:0]);
	endtask

	// Byte i goes to lane i mod 4 of word i/4
	task automatic loadGuess(input logic [7:0] msg [16], input int len);
		logic [31:0] w;
		for (int k = 0; k < 4; k++) begin
			w = {msg[4 * k + 3], msg[4 * k + 2], msg[4 * k + 1], msg[4 * k]};
			apbWrite(md5Pkg::guessAddr0 + 8'(4 * k), w);
		end
		apbWrite(md5Pkg::lenAddr, 32'(len));
	endtask

	task automatic readDigest(output logic [127:0] digest);
		logic [31:0] word;
		for (int k = 0; k < 4; k++) begin
			apbRead(md5Pkg::digestAddr0 + 8'(4 * k), word);
			digest[127 - 32 * k -: 32] = word;
		end
	endtask

	task automatic startHash(input logic [7:0] msg [16], input int len);
		logic [31:0] status;
		loadGuess(msg, len);
		apbWrite(md5Pkg::ctrlAddr, 32'h1);
		startCycle = accessCycle;
		// Busy set, old done cleared
		apbRead(md5Pkg::ctrlAddr, status);
		checkValue("status after start", status, 32'h1);
	endtask

	task automatic finishHash(output int elapsed, output logic [127:0] digest);
		logic [31:0] status;
		status = 32'h0;
		while (status[1] != 1'b1)
			apbRead(md5Pkg::ctrlAddr, status);
		elapsed = accessCycle - startCycle;
		checkValue("status at done", status, 32'h2);
		readDigest(digest);
	endtask

	task automatic runHash(input logic [7:0] msg [16], input int len, output logic [127:0] digest);
		int elapsed;
		startHash(msg, len);
		finishHash(elapsed, digest);
		assert (elapsed <= doneLimit) else begin
			$display("Fail at %0t ns: done seen %0d cycles after start, limit %0d",
				$time, elapsed, doneLimit);
			$display("CHECKS FAILED");
			$fatal(1, "hash too slow");
		end
	endtask

	// Published digest, checked against the model and the DUT
	task automatic checkKnownAnswer(input string text, input logic [127:0] mdHex);
		logic [7:0] msg [16];
		logic [127:0] got;
		logic [127:0] expected;
		for (int i = 0; i < 16; i++)
			msg[i] = (i < text.len()) ? text[i] : 8'h00;
		expected = fromHexDigest(mdHex);
		compareDigest({"model \"", text, "\""}, md5Reference(msg, text.len()), expected);
		runHash(msg, text.len(), got);
		compareDigest({"digest \"", text, "\""}, got, expected);
	endtask

	initial begin
		logic [7:0] msg [16];
		logic [7:0] other [16];
		logic [127:0] got;
		logic [127:0] expected;
		logic [31:0] word;
		int len;
		int elapsed;
		int unsigned seedState;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		accessCycle = 0;
		startCycle = 0;
		lastErr = 1'b0;
		seedState = $urandom(32'h8acc3495);
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;

		// Registers clear after reset
		apbRead(md5Pkg::ctrlAddr, word);
		checkValue("status after reset", word, 32'h0);
		apbRead(md5Pkg::lenAddr, word);
		checkValue("length after reset", word, 32'h0);
		readDigest(got);
		compareDigest("digest after reset", got, 128'h0);

		// Standard test vectors
		checkKnownAnswer("", 128'hd41d8cd98f00b204e9800998ecf8427e);
		checkKnownAnswer("a", 128'h0cc175b9c0f1b6a831c399e269772661);
		checkKnownAnswer("abc", 128'h900150983cd24fb0d6963f7d28e17f72);
		checkKnownAnswer("message digest", 128'hf96b697d7cb7938d525a2f31aaf161d0);

		// Random guesses, junk bytes past the length included
		for (int n = 0; n < randomRuns; n++) begin
			len = int'($urandom % 16);
			for (int i = 0; i < 16; i++)
				msg[i] = 8'($urandom);
			runHash(msg, len, got);
			compareDigest($sformatf("random run %0d", n), got, md5Reference(msg, len));
		end

		// New guess, then a second start, while the hash runs
		len = int'($urandom % 16);
		for (int i = 0; i < 16; i++) begin
			msg[i] = 8'($urandom);
			other[i] = ~msg[i];
		end
		expected = md5Reference(msg, len);
		startHash(msg, len);
		// A restart taken here would hash the other guess
		loadGuess(other, 15 - len);
		apbWrite(md5Pkg::ctrlAddr, 32'h1);
		finishHash(elapsed, got);
		compareDigest("digest with writes during run", got, expected);
		repeat (20) @(posedge clk);
		readDigest(got);
		compareDigest("held digest", got, expected);
		apbRead(md5Pkg::ctrlAddr, word);
		checkValue("status while idle", word, 32'h2);

		// Error response and read-only digest
		apbRead(8'h40, word);
		checkValue("pslverr on read of 0x40", {31'b0, lastErr}, 32'h1);
		apbRead(8'h02, word);
		checkValue("pslverr on read of 0x02", {31'b0, lastErr}, 32'h1);
		apbWrite(8'h18, 32'hffffffff);
		checkValue("pslverr on write to 0x18", {31'b0, lastErr}, 32'h1);
		apbWrite(md5Pkg::digestAddr0, 32'hdeadbeef);
		checkValue("pslverr on digest write", {31'b0, lastErr}, 32'h0);
		readDigest(got);
		compareDigest("digest after write attempt", got, expected);

		// Length keeps only bits 3 to 0
		apbWrite(md5Pkg::lenAddr, 32'h12);
		apbRead(md5Pkg::lenAddr, word);
		checkValue("truncated length", word, 32'h2);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
